/* sound_localizer_top.f */
+incdir+source
source/sound_pkg.sv
source/sample_if.sv
source/mic_array_rx.sv
source/taper_window.sv
source/direction_estimator.sv
source/servo_driver.sv
source/sound_localizer_top.sv
tests/sound_localizer_assertions.sv
tests/sound_localizer_tb.sv

/* Bender.yml */
package:
  name: sound_localizer

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/sound_pkg.sv
      - source/sample_if.sv
      - source/mic_array_rx.sv
      - source/taper_window.sv
      - source/direction_estimator.sv
      - source/servo_driver.sv
      - source/sound_localizer_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/sound_localizer_assertions.sv
      - tests/sound_localizer_tb.sv

/* tests/sound_localizer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_consts.svh"

module sound_localizer_tb;
  import sound_pkg::*;

  localparam int NUM_FRAMES  = 5;
  localparam int TOTAL_SMP   = NUM_FRAMES * `FRAME_LEN;
  // 6 frames of 64 sets at 128 cycles each, plus margin
  localparam int TIMEOUT_CYC = 6 * `FRAME_LEN * 128 + 2000;

  logic        clk_m;
  logic        sys_rst;
  wire  [3:0]  mic_data;
  logic        mic_sck;
  logic        mic_ws;
  logic [3:0]  bin;
  logic        bin_valid;
  logic        servo_pwm;
  logic        overrun;

  mic_sample_t smp [TOTAL_SMP][4];
  bin_t        exp_bin [NUM_FRAMES];
  int          err_cnt;
  int          check_cnt;
  int          bin_cnt;
  bin_t        prev_bin;
  bin_t        filt_bin;
  int          cyc;
  logic        sck_prev;
  logic        ws_prev;
  logic        seen_rise;
  int          sck_gap;
  int          rise_cnt;

  sound_localizer_top dut_i (
    .clk_m     (clk_m),
    .sys_rst   (sys_rst),
    .mic_data  (mic_data),
    .mic_sck   (mic_sck),
    .mic_ws    (mic_ws),
    .bin       (bin),
    .bin_valid (bin_valid),
    .servo_pwm (servo_pwm),
    .overrun   (overrun)
  );

  initial begin
    clk_m = 1'b0;
    forever #10 clk_m = ~clk_m;
  end

  //////////////////////////////
  // stimulus data
  //////////////////////////////

  // amplitude per mic, mic 0 in the low word
  // frame 3 copies mic 1 into mic 3, frame 4 is silent
  function automatic int frame_scale(input int f, input int m);
    logic [63:0] row;
    case (f)
      0:       row = {16'd100, 16'd16000, 16'd4000, 16'd500};
      1:       row = {16'd200, 16'd20000, 16'd5000, 16'd300};
      2:       row = {16'd6000, 16'd800, 16'd200, 16'd24000};
      3:       row = {16'd0, 16'd2000, 16'd12000, 16'd100};
      default: row = '0;
    endcase
    return int'(row[m * 16 +: 16]);
  endfunction

  task automatic make_samples();
    int scale;
    for (int k = 0; k < TOTAL_SMP; k++) begin
      for (int m = 0; m < 4; m++) begin
        scale     = frame_scale(k / `FRAME_LEN, m);
        smp[k][m] = 16'(int'($urandom % (2 * scale + 1)) - scale);
      end
      // exact tie between mic 1 and mic 3
      if (k / `FRAME_LEN == 3) begin
        smp[k][3] = smp[k][1];
      end
    end
  endtask

  // bit b of sample k, msb is bit 0, zeros past the last frame
  function automatic logic sample_bit(input int k, input int m, input int b);
    if (k >= TOTAL_SMP) begin
      return 1'b0;
    end
    return smp[k][m][`SAMPLE_W - 1 - b];
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  // triangular taper, |x| sums, then rank loudest and runner-up
  function automatic bin_t ref_bin(input int f);
    longint energy [4];
    int     n_dist;
    int     coef;
    int     tap;
    int     top;
    int     sec;
    for (int m = 0; m < 4; m++) begin
      energy[m] = 0;
      for (int n = 0; n < `FRAME_LEN; n++) begin
        n_dist = (n < `FRAME_LEN - 1 - n) ? n : `FRAME_LEN - 1 - n;
        coef   = (n_dist + 1) * `TAPER_STEP;
        tap    = (int'(smp[f * `FRAME_LEN + n][m]) * coef) >>> 15;
        if (tap == -32768) begin
          energy[m] += 32767;
        end else begin
          energy[m] += (tap < 0) ? -tap : tap;
        end
      end
    end
    // lower index wins ties
    top = 0;
    for (int m = 1; m < 4; m++) begin
      if (energy[m] > energy[top]) begin
        top = m;
      end
    end
    // runner-up must carry energy, else index 0
    sec = -1;
    for (int m = 0; m < 4; m++) begin
      if (m != top && energy[m] > 0 && (sec < 0 || energy[m] > energy[sec])) begin
        sec = m;
      end
    end
    if (sec < 0) begin
      sec = 0;
    end
    return bin_t'({2'(top), 2'(sec)});
  endfunction

  //////////////////////////////
  // microphone models
  //////////////////////////////

  for (genvar g = 0; g < 4; g++) begin : g_mic
    int   k_smp;
    int   bit_idx;
    logic line;

    assign mic_data[g] = line;

    initial begin
      k_smp   = 0;
      bit_idx = 0;
      line    = 1'b0;
    end

    // left slot bits taken by the receiver
    always @(posedge mic_sck) begin
      if (!mic_ws) begin
        if (bit_idx == `SLOT_BITS - 1) begin
          bit_idx = 0;
          k_smp   = k_smp + 1;
        end else begin
          bit_idx = bit_idx + 1;
        end
      end
    end

    // next bit out just after falling sck, first one after reset
    always @(negedge mic_sck or negedge sys_rst) begin
      #1;
      line = sample_bit(k_smp, g, bit_idx);
    end
  end

  //////////////////////////////
  // checkers
  //////////////////////////////

  // bin per frame, and the servo target tracked from observed bins
  always @(posedge clk_m) begin
    if (!sys_rst && bin_valid) begin
      check_cnt++;
      if (bin_cnt >= NUM_FRAMES) begin
        err_cnt++;
        $display("a direction result came after the last frame at time %0t", $time);
      end else if (bin !== exp_bin[bin_cnt]) begin
        err_cnt++;
        $display("** Error at %0t: frame %0d bin %h, expected %h",
                 $time, bin_cnt, bin, exp_bin[bin_cnt]);
      end
      // two equal bins in a row move the servo
      if (bin == prev_bin) begin
        filt_bin = bin;
      end
      prev_bin = bin;
      bin_cnt++;
    end
  end

  // sck period and ws slot length
  always @(posedge clk_m) begin
    if (sys_rst) begin
      sck_prev  = 1'b0;
      ws_prev   = 1'b0;
      seen_rise = 1'b0;
      sck_gap   = 0;
      rise_cnt  = 0;
    end else begin
      sck_gap++;
      if (mic_sck && !sck_prev) begin
        if (seen_rise) begin
          check_cnt++;
          if (sck_gap != 2 * `SCK_DIV) begin
            err_cnt++;
            $display("** Error at %0t: sck period %0d cycles, expected %0d",
                     $time, sck_gap, 2 * `SCK_DIV);
          end
        end
        seen_rise = 1'b1;
        sck_gap   = 0;
        rise_cnt++;
      end
      if (mic_ws != ws_prev) begin
        check_cnt++;
        if (rise_cnt != `SLOT_BITS) begin
          err_cnt++;
          $display("** Error at %0t: ws changed after %0d sck rises, expected %0d",
                   $time, rise_cnt, `SLOT_BITS);
        end
        rise_cnt = 0;
      end
      sck_prev = mic_sck;
      ws_prev  = mic_ws;
    end
  end

  // high time over one full period, starting at a rising servo_pwm
  task automatic check_pwm(input bin_t target);
    int high_cnt;
    int exp_w;
    high_cnt = 0;
    exp_w    = `SERVO_MIN + int'(target) * `SERVO_STEP;
    @(posedge clk_m);
    while (servo_pwm) begin
      @(posedge clk_m);
    end
    while (!servo_pwm) begin
      @(posedge clk_m);
    end
    repeat (`SERVO_PERIOD) begin
      if (servo_pwm) begin
        high_cnt++;
      end
      @(posedge clk_m);
    end
    check_cnt++;
    if (high_cnt != exp_w) begin
      err_cnt++;
      $display("** Error at %0t: servo high for %0d cycles, expected %0d",
               $time, high_cnt, exp_w);
    end
  endtask

  task automatic wait_bins(input int n);
    while (bin_cnt < n) begin
      @(posedge clk_m);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    sys_rst   = 1'b1;
    err_cnt   = 0;
    check_cnt = 0;
    bin_cnt   = 0;
    prev_bin  = '0;
    filt_bin  = '0;
    void'($urandom(14706));
    make_samples();
    for (int f = 0; f < NUM_FRAMES; f++) begin
      exp_bin[f] = ref_bin(f);
    end
    repeat (5) @(posedge clk_m);
    #1 sys_rst = 1'b0;
    // bin 0 width out of reset
    check_pwm(filt_bin);
    // first two frames agree, servo has moved
    wait_bins(2);
    repeat (`SERVO_PERIOD) @(posedge clk_m);
    check_pwm(filt_bin);
    wait_bins(NUM_FRAMES);
    repeat (`SERVO_PERIOD) @(posedge clk_m);
    check_pwm(filt_bin);
    check_cnt++;
    if (bin_cnt != NUM_FRAMES) begin
      err_cnt++;
      $display("wrong number of direction results: got %0d, expected %0d",
               bin_cnt, NUM_FRAMES);
    end
    check_cnt++;
    if (overrun !== 1'b0) begin
      err_cnt++;
      $display("the overrun flag went high at the rated sample rate");
    end
    err_cnt += dut_i.sva_i.fail_cnt;
    $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // hang guard
  initial begin
    cyc = 0;
    while (cyc < TIMEOUT_CYC) begin
      @(posedge clk_m);
      cyc++;
    end
    $display("timeout: the run was still busy after %0d clock cycles", cyc);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/sound_localizer_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_consts.svh"

module sound_localizer_assertions (
  input logic clk_m,
  input logic sys_rst,
  input logic valid,
  input logic credit,
  input logic bin_valid,
  input logic overrun
);

  int crd;
  int fail_cnt;

  initial fail_cnt = 0;

  //////////////////////////////
  // credit stream
  //////////////////////////////

  // credits as seen on the stream wires alone
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      crd <= `SAMPLE_CREDITS;
    end else begin
      crd <= crd - int'(valid) + int'(credit);
    end
  end

  a_valid_needs_credit: assert property (
    @(posedge clk_m) disable iff (sys_rst) valid |-> (crd > 0)
  ) else begin
    fail_cnt++;
    $error("stream valid with no credit left");
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  a_bin_valid_pulse: assert property (
    @(posedge clk_m) disable iff (sys_rst) bin_valid |=> !bin_valid
  ) else begin
    fail_cnt++;
    $error("bin_valid held longer than one cycle");
  end

  a_no_overrun: assert property (
    @(posedge clk_m) disable iff (sys_rst) !overrun
  ) else begin
    fail_cnt++;
    $error("window overrun at the rated sample rate");
  end

endmodule

bind sound_localizer_top sound_localizer_assertions sva_i (
  .clk_m     (clk_m),
  .sys_rst   (sys_rst),
  .valid     (smp_if.valid),
  .credit    (smp_if.credit),
  .bin_valid (bin_valid),
  .overrun   (overrun)
);

`default_nettype wire

/* source/sound_localizer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sound_localizer_top (
  input  logic       clk_m,
  input  logic       sys_rst,
  input  logic [3:0] mic_data,
  output logic       mic_sck,
  output logic       mic_ws,
  output logic [3:0] bin,
  output logic       bin_valid,
  output logic       servo_pwm,
  output logic       overrun
);
  import sound_pkg::*;

  // raw sets from the mic bus
  mic_set_t rx_set;
  logic     rx_valid;

  // windowed stream, taper to estimator
  sample_if smp_if ();

  //////////////////////////////
  // capture and window
  //////////////////////////////

  mic_array_rx mic_rx_i (
    .clk_m        (clk_m),
    .sys_rst      (sys_rst),
    .mic_data     (mic_data),
    .mic_sck      (mic_sck),
    .mic_ws       (mic_ws),
    .sample_set   (rx_set),
    .sample_valid (rx_valid)
  );

  taper_window taper_i (
    .clk_m        (clk_m),
    .sys_rst      (sys_rst),
    .sample_set   (rx_set),
    .sample_valid (rx_valid),
    .out          (smp_if.source),
    .overrun      (overrun)
  );

  //////////////////////////////
  // direction and servo
  //////////////////////////////

  direction_estimator estim_i (
    .clk_m     (clk_m),
    .sys_rst   (sys_rst),
    .in        (smp_if.sink),
    .bin       (bin),
    .bin_valid (bin_valid)
  );

  // servo follows the raw bin stream, filtering happens inside
  servo_driver servo_i (
    .clk_m     (clk_m),
    .sys_rst   (sys_rst),
    .bin       (bin),
    .bin_valid (bin_valid),
    .servo_pwm (servo_pwm)
  );

endmodule

`default_nettype wire

/* source/servo_driver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_consts.svh"

module servo_driver (
  input  logic            clk_m,
  input  logic            sys_rst,
  input  sound_pkg::bin_t bin,
  input  logic            bin_valid,
  output logic            servo_pwm
);
  import sound_pkg::*;

  localparam int PER_W = $clog2(`SERVO_PERIOD);

  bin_t             bin_hist [2];
  bin_t             servo_bin;
  logic             upd_q;
  logic [PER_W-1:0] per_cnt;
  logic [PER_W-1:0] width;

  //////////////////////////////
  // two-in-a-row filter
  //////////////////////////////

  // [1] is the newest bin, [0] the one before
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      bin_hist[0] <= '0;
      bin_hist[1] <= '0;
      servo_bin   <= '0;
      upd_q       <= 1'b0;
    end else begin
      upd_q <= bin_valid;
      if (bin_valid) begin
        bin_hist[0] <= bin_hist[1];
        bin_hist[1] <= bin;
      end
      // compare once the history has shifted
      if (upd_q && (bin_hist[0] == bin_hist[1])) begin
        servo_bin <= bin_hist[1];
      end
    end
  end

  //////////////////////////////
  // pulse width
  //////////////////////////////

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      per_cnt <= '0;
      width   <= PER_W'(`SERVO_MIN);
    end else begin
      if (per_cnt == PER_W'(`SERVO_PERIOD - 1)) begin
        per_cnt <= '0;
        // new width only at a period boundary
        width   <= PER_W'(`SERVO_MIN + servo_bin * `SERVO_STEP);
      end else begin
        per_cnt <= per_cnt + 1'b1;
      end
    end
  end

  // high for the first width cycles of the period
  assign servo_pwm = (per_cnt < width);

endmodule

`default_nettype wire

/* source/direction_estimator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_consts.svh"

module direction_estimator (
  input  logic            clk_m,
  input  logic            sys_rst,
  sample_if.sink          in,
  output sound_pkg::bin_t bin,
  output logic            bin_valid
);
  import sound_pkg::*;

  localparam int DEPTH = `SAMPLE_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int OCC_W = $clog2(DEPTH + 1);

  mic_set_t         fifo_mem [DEPTH];
  logic             fifo_last [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [OCC_W-1:0] occ;
  logic             pop;
  mic_set_t         cur_set;
  logic             cur_last;
  logic             busy;
  logic [1:0]       mic_idx;
  logic             rank_q;
  energy_t          acc [4];
  mic_sample_t      cur_smp;
  logic [15:0]      mag;
  logic [1:0]       top_idx;
  logic [1:0]       sec_idx;
  energy_t          sec_val;

  //////////////////////////////
  // input buffer
  //////////////////////////////

  // pop when idle, or in the last mic cycle of a set that does not end the frame
  assign pop = (occ != '0) && !rank_q && (!busy || (mic_idx == 2'd3 && !cur_last));
  // a freed slot goes straight back to the source
  assign in.credit = pop;

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (in.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      occ <= occ + OCC_W'(in.valid) - OCC_W'(pop);
    end
  end

  always_ff @(posedge clk_m) begin
    if (in.valid) begin
      fifo_mem[wr_ptr]  <= in.data;
      fifo_last[wr_ptr] <= in.last;
    end
    if (pop) begin
      cur_set  <= fifo_mem[rd_ptr];
      cur_last <= fifo_last[rd_ptr];
    end
  end

  //////////////////////////////
  // energy per mic
  //////////////////////////////

  // |x|, with -32768 clipped to 32767
  always_comb begin
    cur_smp = cur_set[mic_idx];
    if (cur_smp == 16'sh8000) begin
      mag = 16'h7fff;
    end else if (cur_smp[15]) begin
      mag = 16'(-cur_smp);
    end else begin
      mag = cur_smp;
    end
  end

  //////////////////////////////
  // ranking
  //////////////////////////////

  always_comb begin
    // strict compare keeps the lower index on ties
    top_idx = 2'd0;
    for (int i = 1; i < 4; i++) begin
      if (acc[i] > acc[top_idx]) begin
        top_idx = 2'(i);
      end
    end
    // runner-up needs nonzero energy, else index 0
    sec_idx = 2'd0;
    sec_val = '0;
    for (int i = 0; i < 4; i++) begin
      if (2'(i) != top_idx && acc[i] > sec_val) begin
        sec_idx = 2'(i);
        sec_val = acc[i];
      end
    end
  end

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      busy      <= 1'b0;
      mic_idx   <= 2'd0;
      rank_q    <= 1'b0;
      bin       <= '0;
      bin_valid <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        acc[i] <= '0;
      end
    end else begin
      bin_valid <= 1'b0;
      // one mic per cycle
      if (busy) begin
        acc[mic_idx] <= acc[mic_idx] + energy_t'(mag);
        mic_idx      <= mic_idx + 1'b1;
        if (mic_idx == 2'd3) begin
          busy <= 1'b0;
          if (cur_last) begin
            rank_q <= 1'b1;
          end
        end
      end
      // a pop restarts the unit at mic 0
      if (pop) begin
        busy    <= 1'b1;
        mic_idx <= 2'd0;
      end
      // frame done, report and start over
      if (rank_q) begin
        bin       <= {top_idx, sec_idx};
        bin_valid <= 1'b1;
        rank_q    <= 1'b0;
        for (int i = 0; i < 4; i++) begin
          acc[i] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/taper_window.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_consts.svh"

module taper_window (
  input  logic                clk_m,
  input  logic                sys_rst,
  input  sound_pkg::mic_set_t sample_set,
  input  logic                sample_valid,
  sample_if.source            out,
  output logic                overrun
);
  import sound_pkg::*;

  localparam int CNT_W = $clog2(`FRAME_LEN);
  localparam int CRD_W = $clog2(`SAMPLE_CREDITS + 1);

  logic [CNT_W-1:0]   n_cnt;
  logic [CNT_W-1:0]   n_mirror;
  logic [CNT_W-1:0]   n_dist;
  logic [16:0]        coef;
  logic signed [33:0] prod [4];
  mic_set_t           tapered;
  logic               in_last;
  logic [CRD_W-1:0]   credits;
  logic               hold_full;
  logic               send_hold;
  logic               send_new;
  logic               spend;

  //////////////////////////////
  // triangular taper
  //////////////////////////////

  // distance to the nearer frame edge
  assign n_mirror = CNT_W'(`FRAME_LEN - 1) - n_cnt;
  assign n_dist   = (n_cnt < n_mirror) ? n_cnt : n_mirror;
  // 1..32 steps, 32768 means unity in q15
  assign coef     = 17'((n_dist + 1) * `TAPER_STEP);
  assign in_last  = (n_cnt == CNT_W'(`FRAME_LEN - 1));

  always_comb begin
    for (int m = 0; m < 4; m++) begin
      prod[m]    = $signed(sample_set[m]) * $signed({1'b0, coef});
      // >>> 15, result always fits 16 bits
      tapered[m] = prod[m][30:15];
    end
  end

  //////////////////////////////
  // credit flow
  //////////////////////////////

  // a held set goes first, a new one only if nothing is held
  assign send_hold = hold_full && (credits != '0);
  assign send_new  = sample_valid && !hold_full && (credits != '0);
  assign spend     = send_hold || send_new;

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      n_cnt     <= '0;
      credits   <= CRD_W'(`SAMPLE_CREDITS);
      hold_full <= 1'b0;
      out.valid <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      out.valid <= spend;
      credits   <= credits - CRD_W'(spend) + CRD_W'(out.credit);
      // every incoming set counts, even one that is dropped
      if (sample_valid) begin
        n_cnt <= n_cnt + 1'b1;
      end
      if (send_hold) begin
        hold_full <= 1'b0;
      end else if (sample_valid && !hold_full && (credits == '0)) begin
        hold_full <= 1'b1;
      end
      // only one set fits, a second one is lost
      if (sample_valid && hold_full) begin
        overrun <= 1'b1;
      end
    end
  end

  // output register doubles as the hold register
  always_ff @(posedge clk_m) begin
    if (sample_valid && !hold_full) begin
      out.data <= tapered;
      out.last <= in_last;
    end
  end

endmodule

`default_nettype wire

/* source/mic_array_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_consts.svh"

module mic_array_rx (
  input  logic                clk_m,
  input  logic                sys_rst,
  input  logic [3:0]          mic_data,
  output logic                mic_sck,
  output logic                mic_ws,
  output sound_pkg::mic_set_t sample_set,
  output logic                sample_valid
);
  import sound_pkg::*;

  localparam int DIV_W = $clog2(`SCK_DIV);
  localparam int BIT_W = $clog2(`SLOT_BITS);

  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic             sck_edge;
  logic             sck_rise;
  logic             sck_fall;
  logic             last_bit;
  mic_set_t         shreg;

  //////////////////////////////
  // bit clock and word select
  //////////////////////////////

  // sck flips when the divider wraps
  assign sck_edge = (div_cnt == DIV_W'(`SCK_DIV - 1));
  assign sck_rise = sck_edge && !mic_sck;
  assign sck_fall = sck_edge && mic_sck;

  // bit_cnt counts falling edges, so it is the bit index at each rise
  assign last_bit = (bit_cnt == BIT_W'(`SLOT_BITS - 1));

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      div_cnt      <= '0;
      bit_cnt      <= '0;
      mic_sck      <= 1'b0;
      mic_ws       <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      if (sck_edge) begin
        div_cnt <= '0;
        mic_sck <= ~mic_sck;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      // ws moves on the falling sck after the 16th rise
      if (sck_fall) begin
        if (last_bit) begin
          bit_cnt <= '0;
          mic_ws  <= ~mic_ws;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      // set is complete once the last left-slot bit is in
      sample_valid <= sck_rise && !mic_ws && last_bit;
    end
  end

  //////////////////////////////
  // left slot capture
  //////////////////////////////

  // msb first, one bit per rising sck
  always_ff @(posedge clk_m) begin
    if (sck_rise && !mic_ws) begin
      for (int m = 0; m < 4; m++) begin
        shreg[m] <= {shreg[m][`SAMPLE_W-2:0], mic_data[m]};
      end
    end
  end

  // registers stay put through the right slot
  assign sample_set = shreg;

endmodule

`default_nettype wire

/* source/sample_if.sv */
`timescale 1ns/1ps
`default_nettype none

// windowed sample sets, credit flow control
interface sample_if;
  import sound_pkg::*;

  // one cycle per set
  logic     valid;
  mic_set_t data;
  // set FRAME_LEN-1 of the frame
  logic     last;
  // one pulse hands back one buffer slot
  logic     credit;

  modport source (
    output valid,
    output data,
    output last,
    input  credit
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output credit
  );

endinterface

`default_nettype wire

/* source/sound_pkg.sv */
`default_nettype none

`include "sound_consts.svh"

package sound_pkg;

  //////////////////////////////
  // audio data
  //////////////////////////////

  // one two's complement mic sample
  typedef logic signed [`SAMPLE_W-1:0] mic_sample_t;

  // one sample per mic, mic 0 in the low word
  typedef mic_sample_t [3:0] mic_set_t;

  //////////////////////////////
  // direction results
  //////////////////////////////

  // running sum of |sample| over a frame
  typedef logic [31:0] energy_t;

  // upper pair = loudest mic, lower pair = runner-up
  typedef logic [3:0] bin_t;

endpackage

`default_nettype wire

/* source/sound_consts.svh */
`ifndef SOUND_CONSTS_SVH
`define SOUND_CONSTS_SVH

//////////////////////////////
// frame shape
//////////////////////////////

// samples per direction estimate
`define FRAME_LEN 64

// bits per mic word
`define SAMPLE_W 16

//////////////////////////////
// mic bus timing
//////////////////////////////

// clk_m cycles per half sck period
`define SCK_DIV 2

// sck periods per ws half
`define SLOT_BITS 16

//////////////////////////////
// stream and window
//////////////////////////////

// estimator buffer depth, also the starting credit count
`define SAMPLE_CREDITS 4

// taper rises by this much per sample, peak is 32 steps = 1.0
`define TAPER_STEP 1024

//////////////////////////////
// servo
//////////////////////////////

`define SERVO_PERIOD 2000
`define SERVO_MIN 100
`define SERVO_STEP 50

`endif
